//--- source/periph_map_pkg.sv
// Peripheral address map
package periph_map_pkg;

    // Bus and GPIO widths
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;
    localparam int NGPIO      = 32;

    // Upper address nibble picks the peripheral, low byte the register
    localparam int PERIPH_SEL_MSB = 11;
    localparam int PERIPH_SEL_LSB = 8;
    localparam int REG_OFF_W      = 8;

    typedef enum logic [PERIPH_SEL_MSB-PERIPH_SEL_LSB:0] {
        PERIPH_CTRL  = 4'h0,
        PERIPH_GPIO  = 4'h1,
        PERIPH_TIMER = 4'h2
    } periph_id_e;

    typedef enum logic [REG_OFF_W-1:0] {
        CTRL_INFO     = 8'h00,
        CTRL_BOOTADDR = 8'h04,
        CTRL_FETCHEN  = 8'h08
    } ctrl_reg_e;

    typedef enum logic [REG_OFF_W-1:0] {
        GPIO_DIR        = 8'h00,
        GPIO_OUT        = 8'h04,
        GPIO_IN         = 8'h08,
        GPIO_INT_EN     = 8'h0C,
        GPIO_INT_STATUS = 8'h10
    } gpio_reg_e;

    typedef enum logic [REG_OFF_W-1:0] {
        TIMER_CFG     = 8'h00,
        TIMER_COMPARE = 8'h04,
        TIMER_COUNT   = 8'h08
    } timer_reg_e;

    localparam logic [APB_DATA_W-1:0] BOOTADDR_RESET = 32'h1A00_0080;

    // Version 1 in byte 1, number of GPIO lines in byte 0
    localparam logic [APB_DATA_W-1:0] INFO_VALUE = {16'h0000, 8'h01, 8'(NGPIO)};

endpackage

//--- source/periph_event_pkg.sv
// Fabric controller events
package periph_event_pkg;

    localparam int FC_EVENT_W = 32;

    // Event positions in the fabric controller vector
    localparam int FC_EVT_TIMER    = 10;
    localparam int FC_EVT_REF_EDGE = 14;
    localparam int FC_EVT_GPIO     = 15;

    // Timer configuration register fields
    localparam int TIMER_CFG_W   = 3;
    localparam int TIMER_CFG_EN  = 0;
    localparam int TIMER_CFG_REF = 1;
    localparam int TIMER_CFG_CLR = 2;

endpackage

//--- source/apb_periph_decode.sv
// APB peripheral decoder
`timescale 1ns/1ps

module apb_periph_decode (
    input  logic [periph_map_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic [periph_map_pkg::APB_DATA_W-1:0] ctrl_prdata_i,
    input  logic [periph_map_pkg::APB_DATA_W-1:0] gpio_prdata_i,
    input  logic [periph_map_pkg::APB_DATA_W-1:0] timer_prdata_i,
    output logic                                  ctrl_psel_o,
    output logic                                  gpio_psel_o,
    output logic                                  timer_psel_o,
    output logic [periph_map_pkg::APB_DATA_W-1:0] prdata_o,
    output logic                                  pslverr_o
);
    import periph_map_pkg::*;

    periph_id_e region;
    logic       mapped;

    assign region = periph_id_e'(paddr_i[PERIPH_SEL_MSB:PERIPH_SEL_LSB]);

    always_comb begin
        ctrl_psel_o  = 1'b0;
        gpio_psel_o  = 1'b0;
        timer_psel_o = 1'b0;
        prdata_o     = '0;
        mapped       = 1'b1;
        case (region)
            PERIPH_CTRL: begin
                ctrl_psel_o = psel_i;
                prdata_o    = ctrl_prdata_i;
            end
            PERIPH_GPIO: begin
                gpio_psel_o = psel_i;
                prdata_o    = gpio_prdata_i;
            end
            PERIPH_TIMER: begin
                timer_psel_o = psel_i;
                prdata_o     = timer_prdata_i;
            end
            default: mapped = 1'b0;
        endcase
    end

    // Error only in the access phase of an unmapped region
    assign pslverr_o = psel_i & penable_i & ~mapped;

endmodule

//--- source/soc_ctrl_regs.sv
// SoC control registers
`timescale 1ns/1ps

module soc_ctrl_regs (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [periph_map_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [periph_map_pkg::APB_DATA_W-1:0] pwdata_i,
    output logic [periph_map_pkg::APB_DATA_W-1:0] prdata_o,
    output logic [periph_map_pkg::APB_DATA_W-1:0] fc_bootaddr_o,
    output logic                                  fc_fetchen_o
);
    import periph_map_pkg::*;

    ctrl_reg_e             offset;
    logic                  wr_en;
    logic [APB_DATA_W-1:0] bootaddr_q;
    logic                  fetchen_q;

    assign offset = ctrl_reg_e'(paddr_i[REG_OFF_W-1:0]);
    assign wr_en  = psel_i & penable_i & pwrite_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            bootaddr_q <= BOOTADDR_RESET;
            fetchen_q  <= 1'b0;
        end else if (wr_en) begin
            case (offset)
                CTRL_BOOTADDR: bootaddr_q <= pwdata_i;
                CTRL_FETCHEN:  fetchen_q  <= pwdata_i[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (offset)
            CTRL_INFO:     prdata_o = INFO_VALUE;
            CTRL_BOOTADDR: prdata_o = bootaddr_q;
            CTRL_FETCHEN:  prdata_o = {{(APB_DATA_W-1){1'b0}}, fetchen_q};
            default:       prdata_o = '0;
        endcase
    end

    assign fc_bootaddr_o = bootaddr_q;
    assign fc_fetchen_o  = fetchen_q;

endmodule

//--- source/gpio_sync_irq.sv
// GPIO input synchronizer
`timescale 1ns/1ps

module gpio_sync_irq (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic [periph_map_pkg::NGPIO-1:0] gpio_in_i,
    input  logic [periph_map_pkg::NGPIO-1:0] int_en_i,
    output logic [periph_map_pkg::NGPIO-1:0] gpio_sync_o,
    output logic [periph_map_pkg::NGPIO-1:0] gpio_rise_o
);
    import periph_map_pkg::*;

    logic [NGPIO-1:0] meta_q;
    logic [NGPIO-1:0] sync_q;
    logic [NGPIO-1:0] prev_q;

    // Two flop synchronizer plus one stage of history
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            meta_q <= gpio_in_i;
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    assign gpio_sync_o = sync_q;
    assign gpio_rise_o = sync_q & ~prev_q & int_en_i;

endmodule

//--- source/gpio_regs.sv
// GPIO register block
`timescale 1ns/1ps

module gpio_regs (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [periph_map_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [periph_map_pkg::APB_DATA_W-1:0] pwdata_i,
    input  logic [periph_map_pkg::NGPIO-1:0]      gpio_sync_i,
    input  logic [periph_map_pkg::NGPIO-1:0]      gpio_rise_i,
    output logic [periph_map_pkg::APB_DATA_W-1:0] prdata_o,
    output logic [periph_map_pkg::NGPIO-1:0]      gpio_out_o,
    output logic [periph_map_pkg::NGPIO-1:0]      gpio_dir_o,
    output logic [periph_map_pkg::NGPIO-1:0]      int_en_o,
    output logic                                  gpio_irq_o
);
    import periph_map_pkg::*;

    gpio_reg_e        offset;
    logic             wr_en;
    logic [NGPIO-1:0] dir_q;
    logic [NGPIO-1:0] out_q;
    logic [NGPIO-1:0] int_en_q;
    logic [NGPIO-1:0] status_q;
    logic [NGPIO-1:0] status_clr;

    assign offset = gpio_reg_e'(paddr_i[REG_OFF_W-1:0]);
    assign wr_en  = psel_i & penable_i & pwrite_i;

    // Write one to clear status
    assign status_clr = (wr_en && offset == GPIO_INT_STATUS) ? pwdata_i[NGPIO-1:0] : '0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            int_en_q <= '0;
            status_q <= '0;
        end else begin
            if (wr_en) begin
                case (offset)
                    GPIO_DIR:    dir_q    <= pwdata_i[NGPIO-1:0];
                    GPIO_OUT:    out_q    <= pwdata_i[NGPIO-1:0];
                    GPIO_INT_EN: int_en_q <= pwdata_i[NGPIO-1:0];
                    default: ;
                endcase
            end
            // A new rise beats a clear in the same cycle
            status_q <= (status_q & ~status_clr) | gpio_rise_i;
        end
    end

    always_comb begin
        case (offset)
            GPIO_DIR:        prdata_o = APB_DATA_W'(dir_q);
            GPIO_OUT:        prdata_o = APB_DATA_W'(out_q);
            GPIO_IN:         prdata_o = APB_DATA_W'(gpio_sync_i);
            GPIO_INT_EN:     prdata_o = APB_DATA_W'(int_en_q);
            GPIO_INT_STATUS: prdata_o = APB_DATA_W'(status_q);
            default:         prdata_o = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign int_en_o   = int_en_q;
    assign gpio_irq_o = |status_q;

    // Masking happens in the synchronizer a cycle before the status update
    assert property (@(posedge clk_i) disable iff (reset_i)
        (status_q & ~$past(status_q) & ~$past(int_en_q)) == '0)
        else $error("GPIO status set on a masked line");

endmodule

//--- source/timer_core.sv
// Compare timer core
`timescale 1ns/1ps

module timer_core (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     ref_clk_i,
    input  logic [periph_event_pkg::TIMER_CFG_W-1:0] cfg_i,
    input  logic [31:0]                              compare_i,
    output logic [31:0]                              count_o,
    output logic                                     timer_irq_o,
    output logic                                     ref_rise_o,
    output logic                                     ref_fall_o
);
    import periph_event_pkg::*;

    typedef enum logic {
        TIMER_IDLE,
        TIMER_COUNT
    } timer_state_e;

    timer_state_e state_q;
    logic         ref_meta_q;
    logic         ref_sync_q;
    logic         ref_prev_q;
    logic         ref_rise_q;
    logic         ref_fall_q;
    logic         tick;
    logic         match;
    logic         irq_q;
    logic [31:0]  count_q;

    //////////////////////////////////////////////////////////////////////
    // Reference clock synchronizer and edge pulses
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ref_meta_q <= 1'b0;
            ref_sync_q <= 1'b0;
            ref_prev_q <= 1'b0;
            ref_rise_q <= 1'b0;
            ref_fall_q <= 1'b0;
        end else begin
            ref_meta_q <= ref_clk_i;
            ref_sync_q <= ref_meta_q;
            ref_prev_q <= ref_sync_q;
            ref_rise_q <= ref_sync_q & ~ref_prev_q;
            ref_fall_q <= ~ref_sync_q & ref_prev_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Counter
    assign tick  = (state_q == TIMER_COUNT) && (!cfg_i[TIMER_CFG_REF] || ref_rise_q);
    assign match = tick && (count_q == compare_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= TIMER_IDLE;
            count_q <= '0;
            irq_q   <= 1'b0;
        end else begin
            irq_q <= match;
            case (state_q)
                TIMER_IDLE:  if (cfg_i[TIMER_CFG_EN]) state_q <= TIMER_COUNT;
                TIMER_COUNT: if (!cfg_i[TIMER_CFG_EN]) state_q <= TIMER_IDLE;
                default:     state_q <= TIMER_IDLE;
            endcase
            // Idle holds the count
            if (match && cfg_i[TIMER_CFG_CLR]) begin
                count_q <= '0;
            end else if (tick) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    assign count_o     = count_q;
    assign timer_irq_o = irq_q;
    assign ref_rise_o  = ref_rise_q;
    assign ref_fall_o  = ref_fall_q;

    // The pulse lags the match by one clock
    assert property (@(posedge clk_i) disable iff (reset_i)
        timer_irq_o |-> $past(state_q) == TIMER_COUNT)
        else $error("Timer interrupt outside counting state");

endmodule

//--- source/timer_regs.sv
// Timer register block
`timescale 1ns/1ps

module timer_regs (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     psel_i,
    input  logic                                     penable_i,
    input  logic                                     pwrite_i,
    input  logic [periph_map_pkg::APB_ADDR_W-1:0]    paddr_i,
    input  logic [periph_map_pkg::APB_DATA_W-1:0]    pwdata_i,
    input  logic [31:0]                              count_i,
    output logic [periph_map_pkg::APB_DATA_W-1:0]    prdata_o,
    output logic [periph_event_pkg::TIMER_CFG_W-1:0] cfg_o,
    output logic [31:0]                              compare_o
);
    import periph_map_pkg::*;
    import periph_event_pkg::*;

    timer_reg_e             offset;
    logic                   wr_en;
    logic [TIMER_CFG_W-1:0] cfg_q;
    logic [31:0]            compare_q;

    assign offset = timer_reg_e'(paddr_i[REG_OFF_W-1:0]);
    assign wr_en  = psel_i & penable_i & pwrite_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_q <= '0;
        end else if (wr_en && offset == TIMER_CFG) begin
            cfg_q[TIMER_CFG_EN]  <= pwdata_i[TIMER_CFG_EN];
            cfg_q[TIMER_CFG_REF] <= pwdata_i[TIMER_CFG_REF];
            cfg_q[TIMER_CFG_CLR] <= pwdata_i[TIMER_CFG_CLR];
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en && offset == TIMER_COMPARE) begin
            compare_q <= pwdata_i;
        end
    end

    // Count reads live from the core
    always_comb begin
        case (offset)
            TIMER_CFG:     prdata_o = APB_DATA_W'(cfg_q);
            TIMER_COMPARE: prdata_o = compare_q;
            TIMER_COUNT:   prdata_o = count_i;
            default:       prdata_o = '0;
        endcase
    end

    assign cfg_o     = cfg_q;
    assign compare_o = compare_q;

endmodule

//--- source/soc_periph_top.sv
// SoC peripheral subsystem
`timescale 1ns/1ps

module soc_periph_top (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  logic [periph_map_pkg::APB_ADDR_W-1:0]   paddr_i,
    input  logic                                    psel_i,
    input  logic                                    penable_i,
    input  logic                                    pwrite_i,
    input  logic [periph_map_pkg::APB_DATA_W-1:0]   pwdata_i,
    output logic [periph_map_pkg::APB_DATA_W-1:0]   prdata_o,
    output logic                                    pready_o,
    output logic                                    pslverr_o,
    input  logic                                    ref_clk_i,
    input  logic [periph_map_pkg::NGPIO-1:0]        gpio_in_i,
    output logic [periph_map_pkg::NGPIO-1:0]        gpio_out_o,
    output logic [periph_map_pkg::NGPIO-1:0]        gpio_dir_o,
    output logic [periph_map_pkg::APB_DATA_W-1:0]   fc_bootaddr_o,
    output logic                                    fc_fetchen_o,
    output logic [periph_event_pkg::FC_EVENT_W-1:0] fc_events_o
);
    import periph_map_pkg::*;
    import periph_event_pkg::*;

    logic                   ctrl_psel;
    logic                   gpio_psel;
    logic                   timer_psel;
    logic [APB_DATA_W-1:0]  ctrl_prdata;
    logic [APB_DATA_W-1:0]  gpio_prdata;
    logic [APB_DATA_W-1:0]  timer_prdata;
    logic [NGPIO-1:0]       gpio_sync;
    logic [NGPIO-1:0]       gpio_rise;
    logic [NGPIO-1:0]       gpio_int_en;
    logic                   gpio_irq;
    logic [TIMER_CFG_W-1:0] timer_cfg;
    logic [31:0]            timer_compare;
    logic [31:0]            timer_count;
    logic                   timer_irq;
    logic                   ref_rise;
    logic                   ref_fall;

    // Zero wait state slaves
    assign pready_o = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Bus decode and control block
    apb_periph_decode u_decode (
        .paddr_i        ( paddr_i      ),
        .psel_i         ( psel_i       ),
        .penable_i      ( penable_i    ),
        .ctrl_prdata_i  ( ctrl_prdata  ),
        .gpio_prdata_i  ( gpio_prdata  ),
        .timer_prdata_i ( timer_prdata ),
        .ctrl_psel_o    ( ctrl_psel    ),
        .gpio_psel_o    ( gpio_psel    ),
        .timer_psel_o   ( timer_psel   ),
        .prdata_o       ( prdata_o     ),
        .pslverr_o      ( pslverr_o    )
    );

    soc_ctrl_regs u_ctrl (
        .clk_i         ( clk_i         ),
        .reset_i       ( reset_i       ),
        .psel_i        ( ctrl_psel     ),
        .penable_i     ( penable_i     ),
        .pwrite_i      ( pwrite_i      ),
        .paddr_i       ( paddr_i       ),
        .pwdata_i      ( pwdata_i      ),
        .prdata_o      ( ctrl_prdata   ),
        .fc_bootaddr_o ( fc_bootaddr_o ),
        .fc_fetchen_o  ( fc_fetchen_o  )
    );

    //////////////////////////////////////////////////////////////////////
    // GPIO
    gpio_regs u_gpio_regs (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .psel_i      ( gpio_psel   ),
        .penable_i   ( penable_i   ),
        .pwrite_i    ( pwrite_i    ),
        .paddr_i     ( paddr_i     ),
        .pwdata_i    ( pwdata_i    ),
        .gpio_sync_i ( gpio_sync   ),
        .gpio_rise_i ( gpio_rise   ),
        .prdata_o    ( gpio_prdata ),
        .gpio_out_o  ( gpio_out_o  ),
        .gpio_dir_o  ( gpio_dir_o  ),
        .int_en_o    ( gpio_int_en ),
        .gpio_irq_o  ( gpio_irq    )
    );

    gpio_sync_irq u_gpio_sync (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .gpio_in_i   ( gpio_in_i   ),
        .int_en_i    ( gpio_int_en ),
        .gpio_sync_o ( gpio_sync   ),
        .gpio_rise_o ( gpio_rise   )
    );

    //////////////////////////////////////////////////////////////////////
    // Timer
    timer_regs u_timer_regs (
        .clk_i     ( clk_i         ),
        .reset_i   ( reset_i       ),
        .psel_i    ( timer_psel    ),
        .penable_i ( penable_i     ),
        .pwrite_i  ( pwrite_i      ),
        .paddr_i   ( paddr_i       ),
        .pwdata_i  ( pwdata_i      ),
        .count_i   ( timer_count   ),
        .prdata_o  ( timer_prdata  ),
        .cfg_o     ( timer_cfg     ),
        .compare_o ( timer_compare )
    );

    timer_core u_timer_core (
        .clk_i       ( clk_i         ),
        .reset_i     ( reset_i       ),
        .ref_clk_i   ( ref_clk_i     ),
        .cfg_i       ( timer_cfg     ),
        .compare_i   ( timer_compare ),
        .count_o     ( timer_count   ),
        .timer_irq_o ( timer_irq     ),
        .ref_rise_o  ( ref_rise      ),
        .ref_fall_o  ( ref_fall      )
    );

    //////////////////////////////////////////////////////////////////////
    // Fabric controller event vector, unused positions held low
    always_comb begin
        fc_events_o                  = '0;
        fc_events_o[FC_EVT_TIMER]    = timer_irq;
        fc_events_o[FC_EVT_REF_EDGE] = ref_rise | ref_fall;
        fc_events_o[FC_EVT_GPIO]     = gpio_irq;
    end

endmodule

//--- verification/tb_soc_periph_tasks.svh
// Testbench bus and check tasks

// Compares one value and logs a mismatch
task automatic check_value(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, expected);
    end
endtask

// One APB transfer, setup phase then access phase until pready
task automatic apb_transfer(input logic is_write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    @(posedge clk_i);
    paddr_i   <= addr;
    pwrite_i  <= is_write;
    pwdata_i  <= wdata;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    @(posedge clk_i);
    penable_i <= 1'b1;
    waits = 0;
    @(negedge clk_i);
    while (pready_o !== 1'b1 && waits < BUS_TIMEOUT) begin
        @(negedge clk_i);
        waits++;
    end
    rdata = prdata_o;
    err   = pslverr_o;
    if (pready_o !== 1'b1) begin
        $display("APB transfer to address %h got no pready within %0d cycles", addr, waits);
        error_count++;
        timed_out = 1'b1;
    end
    // Write lands on this edge
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
endtask

task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, addr, data, rdata, err);
endtask

task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] rdata,
                        output logic err);
    apb_transfer(1'b0, addr, '0, rdata, err);
endtask

// Waits for an event bit to reach a level, sampled between edges
task automatic wait_event(input int bit_idx, input logic [31:0] limit, input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (fc_events_o[bit_idx] !== level && cycles < int'(limit)) begin
        @(negedge clk_i);
        cycles++;
    end
    if (fc_events_o[bit_idx] !== level) begin
        $display("Event bit %0d did not reach %b within %0d cycles", bit_idx, level, limit);
        error_count++;
        timed_out = 1'b1;
    end
endtask

//--- verification/tb_soc_periph.sv
// Peripheral subsystem testbench
`timescale 1ns/1ps

module tb_soc_periph;
    import periph_map_pkg::*;
    import periph_event_pkg::*;

    localparam int CLK_HALF      = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int MAX_RECORDS   = 64;
    localparam int SETTLE_CYCLES = 4;
    localparam int BUS_TIMEOUT   = 16;
    localparam int EDGE_TIMEOUT  = 8;

    // Only these event positions may ever be high
    localparam logic [31:0] EVT_MAPPED = (32'd1 << FC_EVT_TIMER) |
                                         (32'd1 << FC_EVT_REF_EDGE) |
                                         (32'd1 << FC_EVT_GPIO);

    typedef enum logic [3:0] {
        OP_WRITE = 4'h0,
        OP_READ  = 4'h1,
        OP_GPIO  = 4'h2,
        OP_REF   = 4'h3,
        OP_WAIT  = 4'h4,
        OP_END   = 4'hF
    } cmd_op_e;

    logic                  clk_i;
    logic                  reset_i;
    logic [APB_ADDR_W-1:0] paddr_i;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    logic [APB_DATA_W-1:0] pwdata_i;
    logic [APB_DATA_W-1:0] prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    logic                  ref_clk_i;
    logic [NGPIO-1:0]      gpio_in_i;
    logic [NGPIO-1:0]      gpio_out_o;
    logic [NGPIO-1:0]      gpio_dir_o;
    logic [APB_DATA_W-1:0] fc_bootaddr_o;
    logic                  fc_fetchen_o;
    logic [FC_EVENT_W-1:0] fc_events_o;

    // Four words per record: opcode, address, data, expected
    logic [31:0] tests [0:4*MAX_RECORDS-1];
    int          error_count = 0;
    int          check_count = 0;
    logic        timed_out   = 1'b0;

    `include "tb_soc_periph_tasks.svh"

    soc_periph_top u_dut (
        .clk_i         ( clk_i         ),
        .reset_i       ( reset_i       ),
        .paddr_i       ( paddr_i       ),
        .psel_i        ( psel_i        ),
        .penable_i     ( penable_i     ),
        .pwrite_i      ( pwrite_i      ),
        .pwdata_i      ( pwdata_i      ),
        .prdata_o      ( prdata_o      ),
        .pready_o      ( pready_o      ),
        .pslverr_o     ( pslverr_o     ),
        .ref_clk_i     ( ref_clk_i     ),
        .gpio_in_i     ( gpio_in_i     ),
        .gpio_out_o    ( gpio_out_o    ),
        .gpio_dir_o    ( gpio_dir_o    ),
        .fc_bootaddr_o ( fc_bootaddr_o ),
        .fc_fetchen_o  ( fc_fetchen_o  ),
        .fc_events_o   ( fc_events_o   )
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic bit region_mapped(input logic [APB_ADDR_W-1:0] addr);
        logic [PERIPH_SEL_MSB-PERIPH_SEL_LSB:0] region;
        region = addr[PERIPH_SEL_MSB:PERIPH_SEL_LSB];
        return region == PERIPH_CTRL || region == PERIPH_GPIO || region == PERIPH_TIMER;
    endfunction

    // Registers with a port copy must show the same value on the port
    task automatic check_outputs(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] expected);
        @(negedge clk_i);
        case (addr)
            {PERIPH_CTRL, CTRL_BOOTADDR}: check_value("fc_bootaddr_o", fc_bootaddr_o, expected);
            {PERIPH_CTRL, CTRL_FETCHEN}:  check_value("fc_fetchen_o", 32'(fc_fetchen_o), expected);
            {PERIPH_GPIO, GPIO_DIR}:      check_value("gpio_dir_o", 32'(gpio_dir_o), expected);
            {PERIPH_GPIO, GPIO_OUT}:      check_value("gpio_out_o", 32'(gpio_out_o), expected);
            default: ;
        endcase
    endtask

    // Each toggle must give one edge event
    task automatic toggle_ref(input logic [31:0] count);
        for (int n = 0; n < int'(count) && !timed_out; n++) begin
            @(posedge clk_i);
            ref_clk_i <= ~ref_clk_i;
            wait_event(FC_EVT_REF_EDGE, EDGE_TIMEOUT, 1'b1);
        end
    endtask

    always @(negedge clk_i) begin
        if (!reset_i) begin
            check_value("unmapped event bits", fc_events_o & ~EVT_MAPPED, '0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Command loop

    initial begin
        int                    idx;
        logic                  done;
        cmd_op_e               op;
        logic [APB_ADDR_W-1:0] addr;
        logic [31:0]           data;
        logic [31:0]           expected;
        logic [31:0]           rdata;
        logic                  err;
        int unsigned           seed_ret;
        seed_ret  = $urandom(32'h0f262815);
        reset_i   = 1'b1;
        paddr_i   = '0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        pwdata_i  = '0;
        ref_clk_i = 1'b0;
        gpio_in_i = '0;
        $readmemh("verification/soc_periph_tests.mem", tests);
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i <= 1'b0;
        idx  = 0;
        done = 1'b0;
        while (!done && !timed_out && idx < MAX_RECORDS) begin
            op       = cmd_op_e'(tests[4*idx][3:0]);
            addr     = tests[4*idx+1][APB_ADDR_W-1:0];
            data     = tests[4*idx+2];
            expected = tests[4*idx+3];
            case (op)
                OP_WRITE: apb_write(addr, data);
                OP_READ: begin
                    // Data column is a compare mask
                    apb_read(addr, rdata, err);
                    check_value($sformatf("read of %h", addr), rdata & data, expected);
                    check_value($sformatf("pslverr of %h", addr), 32'(err),
                                32'(!region_mapped(addr)));
                    if (data == '1) begin
                        check_outputs(addr, expected);
                    end
                end
                OP_GPIO: begin
                    @(posedge clk_i);
                    gpio_in_i <= data[NGPIO-1:0];
                    repeat (SETTLE_CYCLES) @(posedge clk_i);
                end
                OP_REF:  toggle_ref(data);
                OP_WAIT: wait_event(int'(addr), data, expected[0]);
                OP_END:  done = 1'b1;
                default: begin
                    $display("Unknown opcode %h in record %0d", op, idx);
                    error_count++;
                    done = 1'b1;
                end
            endcase
            idx++;
            repeat ($urandom % 4) @(posedge clk_i);
        end
        if (!done && !timed_out) begin
            $display("Command list ran out without an end record");
            error_count++;
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+verification
source/periph_map_pkg.sv
source/periph_event_pkg.sv
source/apb_periph_decode.sv
source/soc_ctrl_regs.sv
source/gpio_sync_irq.sv
source/gpio_regs.sv
source/timer_core.sv
source/timer_regs.sv
source/soc_periph_top.sv
verification/tb_soc_periph.sv

//--- Makefile
# Verilator build and run of the peripheral subsystem testbench

SIM     := obj_dir/Vtb_soc_periph
SOURCES := flist.f $(wildcard source/*.sv) $(wildcard verification/*.sv verification/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module tb_soc_periph -f flist.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

//--- verification/soc_periph_tests.mem
// Columns: opcode address data expected
// 0 write, 1 read (data masks the compare), 2 gpio_in, 3 ref toggles, 4 event wait, f end
00000001 00000004 FFFFFFFF 1A000080
00000001 00000000 FFFFFFFF 00000120
00000001 00000008 FFFFFFFF 00000000
00000000 00000004 1C008000 00000000
00000000 00000008 00000001 00000000
00000001 00000004 FFFFFFFF 1C008000
00000001 00000008 FFFFFFFF 00000001
00000001 00000100 FFFFFFFF 00000000
00000000 00000100 0000FF0F 00000000
00000000 00000104 A5A5C3C3 00000000
00000001 00000100 FFFFFFFF 0000FF0F
00000001 00000104 FFFFFFFF A5A5C3C3
00000002 00000000 12345678 00000000
00000001 00000108 FFFFFFFF 12345678
00000002 00000000 00000000 00000000
00000000 0000010C 00000010 00000000
// Line 5 is masked, line 4 is enabled
00000002 00000000 00000020 00000000
00000001 00000110 FFFFFFFF 00000000
00000004 0000000F 00000010 00000000
00000002 00000000 00000030 00000000
00000004 0000000F 00000010 00000001
00000001 00000110 FFFFFFFF 00000010
00000000 00000110 00000010 00000000
00000004 0000000F 00000010 00000000
// Timer with compare 3 and clear on match
00000000 00000204 00000003 00000000
00000000 00000200 00000005 00000000
00000004 0000000A 00000028 00000001
00000000 00000200 00000004 00000000
00000001 00000208 FFFFFFFC 00000000
00000003 00000000 00000006 00000000
00000001 00000304 FFFFFFFF 00000000
0000000F 00000000 00000000 00000000
